// File: mmio_tie_off_pkg.sv
package mmio_tie_off_pkg;

    // Request header fields as seen on the RX stream

    // TLP format and type byte
    typedef logic [7:0] t_fmt_type;

    // Request length in DW
    typedef logic [9:0] t_length;

    // Requester or completer ID
    typedef logic [15:0] t_req_id;

    // Extended 10-bit tag
    typedef logic [9:0] t_tag;

    // Address word, 3DW requests carry their address in the upper half
    typedef logic [63:0] t_addr;

    // Completion header fields

    // Low address of the first returned byte
    typedef logic [6:0] t_low_addr;

    // Remaining byte count of the completion
    typedef logic [11:0] t_byte_count;

    // Function numbers of the slot being tied off
    typedef logic [2:0] t_pf_num;
    typedef logic [10:0] t_vf_num;

    // One 64-bit CSR and its byte enables
    typedef logic [63:0] t_csr_data;
    typedef logic [7:0] t_data_keep;

    // Register index, taken from low address bits 6:3
    typedef logic [3:0] t_reg_index;

    // Memory read requests
    // Bit 5 set means a 4DW header with a 64-bit address
    localparam t_fmt_type FMT_MRD32 = 8'h00;
    localparam t_fmt_type FMT_MRD64 = 8'h20;

    // Completion with data
    localparam t_fmt_type FMT_CPLD = 8'h4A;

    // AFU device feature header
    // Feature type AFU in 63:60, end of list in bit 40
    localparam t_csr_data AFU_DFH_VALUE = 64'h1000_0100_0000_0000;

    // Fixed upper half of the AFU ID
    localparam t_csr_data AFU_ID_H_VALUE = 64'hd15ab1ed_00000000;

    // Register map, 8 bytes per register
    localparam t_reg_index REG_DFH = 4'd0;
    localparam t_reg_index REG_ID_L = 4'd1;
    localparam t_reg_index REG_ID_H = 4'd2;

endpackage

// File: mmio_stage_if.sv
interface mmio_stage_if
    import mmio_tie_off_pkg::*;
;

    // Handshake
    logic valid;
    logic ready;

    // Request fields needed to form the completion
    t_req_id req_id;
    t_tag tag;
    t_length length;
    t_low_addr low_addr;

    // Register value, only meaningful from lookup to encode
    t_csr_data data;

    // Producer side of a link
    modport src (
        output valid, req_id, tag, length, low_addr, data,
        input ready
    );

    // Consumer side of a link
    modport dst (
        input valid, req_id, tag, length, low_addr, data,
        output ready
    );

endinterface

// File: mmio_req_decode.sv
module mmio_req_decode
    import mmio_tie_off_pkg::*;
(
    input logic csr_clk,
    input logic csr_reset_n,

    // RX request stream, one header per beat
    input logic rx_valid,
    input logic rx_sop,
    input t_fmt_type rx_fmt_type,
    input t_length rx_length,
    input t_req_id rx_req_id,
    input t_tag rx_tag,
    input t_addr rx_addr,
    output logic rx_ready,

    // Decoded read toward the lookup stage
    mmio_stage_if.src req
);

    // Holding register state
    logic hold_valid;
    t_req_id hold_req_id;
    t_tag hold_tag;
    t_length hold_length;
    t_low_addr hold_low_addr;

    // Decode of the current beat
    logic beat_is_mrd;
    logic beat_take;
    t_low_addr beat_low_addr;

    // Free when empty or when the held read moves on this cycle
    assign rx_ready = !hold_valid || req.ready;

    // Only the header beat of an MRd is of interest
    assign beat_is_mrd = rx_sop &&
                         ((rx_fmt_type == FMT_MRD32) || (rx_fmt_type == FMT_MRD64));

    // Beat accepted and kept
    assign beat_take = rx_valid && rx_ready && beat_is_mrd;

    // 4DW headers carry the low address bits in the low word
    // A 3DW address sits in the upper word of the stream
    always_comb
    begin
        if (rx_fmt_type == FMT_MRD64)
        begin
            beat_low_addr = rx_addr[6:0];
        end
        else
        begin
            beat_low_addr = rx_addr[38:32];
        end
    end

    // Occupancy
    // Anything accepted that is not an MRd simply leaves the stage empty
    always_ff @(posedge csr_clk)
    begin
        if (!csr_reset_n)
        begin
            hold_valid <= 1'b0;
        end
        else if (rx_ready)
        begin
            hold_valid <= rx_valid && beat_is_mrd;
        end
    end

    // Completion-relevant fields of the read
    always_ff @(posedge csr_clk)
    begin
        if (beat_take)
        begin
            hold_req_id <= rx_req_id;
            hold_tag <= rx_tag;
            hold_length <= rx_length;
            hold_low_addr <= beat_low_addr;
        end
    end

    assign req.valid = hold_valid;
    assign req.req_id = hold_req_id;
    assign req.tag = hold_tag;
    assign req.length = hold_length;
    assign req.low_addr = hold_low_addr;

    // No register value exists yet at this point
    assign req.data = '0;

endmodule

// File: mmio_reg_lookup.sv
module mmio_reg_lookup
    import mmio_tie_off_pkg::*;
(
    input logic csr_clk,
    input logic csr_reset_n,

    // Function numbers of the slot
    input t_pf_num pf_num,
    input t_vf_num vf_num,
    input logic vf_active,

    // Decoded read in, looked-up value out
    mmio_stage_if.dst req,
    mmio_stage_if.src rsp
);

    // Output register
    logic out_valid;
    t_req_id out_req_id;
    t_tag out_tag;
    t_length out_length;
    t_low_addr out_low_addr;
    t_csr_data out_data;

    // Register selection
    t_reg_index reg_index;
    t_csr_data reg_value;
    t_csr_data rd_data;

    // Take a new read when empty or when encode takes ours
    assign req.ready = !out_valid || rsp.ready;

    assign reg_index = req.low_addr[6:3];

    // Small fixed register map
    always_comb
    begin
        reg_value = '0;
        case (reg_index)
            REG_DFH:
            begin
                reg_value = AFU_DFH_VALUE;
            end
            REG_ID_L:
            begin
                // Function numbers identify the slot
                reg_value[63:56] = vf_num[7:0];
                reg_value[52] = vf_active;
                reg_value[51:48] = {1'b0, pf_num};
            end
            REG_ID_H:
            begin
                reg_value = AFU_ID_H_VALUE;
            end
            default:
            begin
                reg_value = '0;
            end
        endcase

        // Short read of the upper half of a register
        rd_data = reg_value;
        if (req.low_addr[2])
        begin
            rd_data[31:0] = reg_value[63:32];
        end
    end

    always_ff @(posedge csr_clk)
    begin
        if (!csr_reset_n)
        begin
            out_valid <= 1'b0;
        end
        else if (req.ready)
        begin
            out_valid <= req.valid;
        end
    end

    // Request fields pass through with the value
    always_ff @(posedge csr_clk)
    begin
        if (req.valid && req.ready)
        begin
            out_req_id <= req.req_id;
            out_tag <= req.tag;
            out_length <= req.length;
            out_low_addr <= req.low_addr;
            out_data <= rd_data;
        end
    end

    assign rsp.valid = out_valid;
    assign rsp.req_id = out_req_id;
    assign rsp.tag = out_tag;
    assign rsp.length = out_length;
    assign rsp.low_addr = out_low_addr;
    assign rsp.data = out_data;

endmodule

// File: mmio_cpl_encode.sv
module mmio_cpl_encode
    import mmio_tie_off_pkg::*;
(
    input logic csr_clk,
    input logic csr_reset_n,

    // Function numbers, used for the completer ID
    input t_pf_num pf_num,
    input t_vf_num vf_num,
    input logic vf_active,

    // Looked-up read from the lookup stage
    mmio_stage_if.dst rsp,

    // TX completion stream
    input logic tx_ready,
    output logic tx_valid,
    output t_fmt_type tx_fmt_type,
    output t_length tx_length,
    output t_req_id tx_req_id,
    output t_req_id tx_comp_id,
    output t_tag tx_tag,
    output t_byte_count tx_byte_count,
    output t_low_addr tx_low_addr,
    output t_csr_data tx_data,
    output t_data_keep tx_keep
);

    // Completion fields derived from the response
    logic cpl_take;
    t_req_id cpl_comp_id;
    t_byte_count cpl_byte_count;
    t_low_addr cpl_low_addr;
    t_data_keep cpl_keep;

    // Room when empty or when the held completion leaves
    assign rsp.ready = !tx_valid || tx_ready;

    assign cpl_take = rsp.valid && rsp.ready;

    // Every completion from this slot is a CplD
    assign tx_fmt_type = FMT_CPLD;

    // Zero MSB, then VF, VF active and PF
    assign cpl_comp_id = {1'b0, vf_num, vf_active, pf_num};

    // Whole request returned in one completion
    assign cpl_byte_count = {rsp.length, 2'b00};

    // DW aligned
    assign cpl_low_addr = {rsp.low_addr[6:2], 2'b00};

    // One DW or both halves of the register
    assign cpl_keep = (rsp.length > 10'd1) ? 8'hff : 8'h0f;

    // Output valid, held under back-pressure
    always_ff @(posedge csr_clk)
    begin
        if (!csr_reset_n)
        begin
            tx_valid <= 1'b0;
        end
        else if (rsp.ready)
        begin
            tx_valid <= rsp.valid;
        end
    end

    // Completion payload
    always_ff @(posedge csr_clk)
    begin
        if (cpl_take)
        begin
            tx_length <= rsp.length;
            tx_req_id <= rsp.req_id;
            tx_comp_id <= cpl_comp_id;
            tx_tag <= rsp.tag;
            tx_byte_count <= cpl_byte_count;
            tx_low_addr <= cpl_low_addr;
            tx_data <= rsp.data;
            tx_keep <= cpl_keep;
        end
    end

endmodule

// File: mmio_tie_off_top.sv
module mmio_tie_off_top
    import mmio_tie_off_pkg::*;
(
    input logic csr_clk,
    input logic csr_reset_n,

    // RX request stream
    input logic rx_valid,
    input logic rx_sop,
    input t_fmt_type rx_fmt_type,
    input t_length rx_length,
    input t_req_id rx_req_id,
    input t_tag rx_tag,
    input t_addr rx_addr,
    output logic rx_ready,

    // TX completion stream
    input logic tx_ready,
    output logic tx_valid,
    output t_fmt_type tx_fmt_type,
    output t_length tx_length,
    output t_req_id tx_req_id,
    output t_tag tx_tag,
    output t_req_id tx_comp_id,
    output t_byte_count tx_byte_count,
    output t_low_addr tx_low_addr,
    output t_csr_data tx_data,
    output t_data_keep tx_keep,

    // Slot identity
    input t_pf_num pf_num,
    input t_vf_num vf_num,
    input logic vf_active
);

    // Links between the three stages
    mmio_stage_if dec_to_lkp ();
    mmio_stage_if lkp_to_enc ();

    // Filter the RX stream down to MRd headers
    mmio_req_decode u_req_decode (
        .csr_clk (csr_clk),
        .csr_reset_n (csr_reset_n),
        .rx_valid (rx_valid),
        .rx_sop (rx_sop),
        .rx_fmt_type (rx_fmt_type),
        .rx_length (rx_length),
        .rx_req_id (rx_req_id),
        .rx_tag (rx_tag),
        .rx_addr (rx_addr),
        .rx_ready (rx_ready),
        .req (dec_to_lkp.src)
    );

    // Register map read
    mmio_reg_lookup u_reg_lookup (
        .csr_clk (csr_clk),
        .csr_reset_n (csr_reset_n),
        .pf_num (pf_num),
        .vf_num (vf_num),
        .vf_active (vf_active),
        .req (dec_to_lkp.dst),
        .rsp (lkp_to_enc.src)
    );

    // CplD formation and TX hold
    mmio_cpl_encode u_cpl_encode (
        .csr_clk (csr_clk),
        .csr_reset_n (csr_reset_n),
        .pf_num (pf_num),
        .vf_num (vf_num),
        .vf_active (vf_active),
        .rsp (lkp_to_enc.dst),
        .tx_ready (tx_ready),
        .tx_valid (tx_valid),
        .tx_fmt_type (tx_fmt_type),
        .tx_length (tx_length),
        .tx_req_id (tx_req_id),
        .tx_comp_id (tx_comp_id),
        .tx_tag (tx_tag),
        .tx_byte_count (tx_byte_count),
        .tx_low_addr (tx_low_addr),
        .tx_data (tx_data),
        .tx_keep (tx_keep)
    );

endmodule

// File: tb_mmio_tie_off.sv
module tb_mmio_tie_off
    import mmio_tie_off_pkg::*;
;

    // Cycles any single wait may take
    localparam int WAIT_LIMIT = 200;
    localparam int STREAM_LEN = 40;

    // One expected completion
    typedef struct packed {
        t_req_id req_id;
        t_req_id comp_id;
        t_tag tag;
        t_length length;
        t_byte_count byte_count;
        t_low_addr low_addr;
        t_csr_data data;
        t_data_keep keep;
    } cpl_t;

    logic csr_clk;
    logic csr_reset_n;
    logic rx_valid;
    logic rx_sop;
    t_fmt_type rx_fmt_type;
    t_length rx_length;
    t_req_id rx_req_id;
    t_tag rx_tag;
    t_addr rx_addr;
    logic rx_ready;
    logic tx_ready;
    logic tx_valid;
    t_fmt_type tx_fmt_type;
    t_length tx_length;
    t_req_id tx_req_id;
    t_tag tx_tag;
    t_req_id tx_comp_id;
    t_byte_count tx_byte_count;
    t_low_addr tx_low_addr;
    t_csr_data tx_data;
    t_data_keep tx_keep;
    t_pf_num pf_num;
    t_vf_num vf_num;
    logic vf_active;

    logic [31:0] lcg_state;
    logic stream_done;

    // Completions still owed, oldest first
    cpl_t exp_q[$];

    mmio_tie_off_top dut (.*);

    always #5 csr_clk = ~csr_clk;

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // Expected completion for one MRd header
    function automatic cpl_t model_cpl(input t_fmt_type fmt, input t_addr addr,
                                       input t_length len, input t_req_id req_id,
                                       input t_tag tag);
        cpl_t c;
        t_low_addr low;
        // 3DW address lives in the upper word
        low = (fmt == FMT_MRD64) ? addr[6:0] : addr[38:32];
        c.data = '0;
        case (low[6:3])
            REG_DFH: c.data = AFU_DFH_VALUE;
            REG_ID_H: c.data = AFU_ID_H_VALUE;
            REG_ID_L:
            begin
                c.data[63:56] = vf_num[7:0];
                c.data[52] = vf_active;
                c.data[50:48] = pf_num;
            end
            default: c.data = '0;
        endcase
        // Upper half of the register for an odd DW
        if (low[2])
            c.data[31:0] = c.data[63:32];
        c.req_id = req_id;
        c.comp_id = {1'b0, vf_num, vf_active, pf_num};
        c.tag = tag;
        c.length = len;
        c.byte_count = t_byte_count'(len) * 12'd4;
        c.low_addr = {low[6:2], 2'b00};
        c.keep = (len > 10'd1) ? 8'hff : 8'h0f;
        return c;
    endfunction

    task automatic stop_on_error(input string msg);
        $display("%s", msg);
        $display("TEST RESULT: FAIL");
        $fatal(1, "simulation stopped on the first error");
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (act !== exp)
            stop_on_error($sformatf("FAILED %s: expected 0x%h, got 0x%h", name, exp, act));
    endtask

    task automatic check_fmt(input string name, input t_fmt_type exp, input t_fmt_type act);
        if (act !== exp)
            stop_on_error($sformatf("FAILED %s: expected 0x%h, got 0x%h", name, exp, act));
    endtask

    task automatic check_data(input string name, input t_csr_data exp, input t_csr_data act);
        if (act !== exp)
            stop_on_error($sformatf("FAILED %s: expected 0x%h, got 0x%h", name, exp, act));
    endtask

    task automatic check_id(input string name, input t_req_id exp, input t_req_id act);
        if (act !== exp)
            stop_on_error($sformatf("FAILED %s: expected 0x%h, got 0x%h", name, exp, act));
    endtask

    task automatic check_tag(input string name, input t_tag exp, input t_tag act);
        if (act !== exp)
            stop_on_error($sformatf("FAILED %s: expected 0x%h, got 0x%h", name, exp, act));
    endtask

    task automatic check_length(input string name, input t_length exp, input t_length act);
        if (act !== exp)
            stop_on_error($sformatf("FAILED %s: expected 0x%h, got 0x%h", name, exp, act));
    endtask

    task automatic check_count(input string name, input t_byte_count exp,
                               input t_byte_count act);
        if (act !== exp)
            stop_on_error($sformatf("FAILED %s: expected 0x%h, got 0x%h", name, exp, act));
    endtask

    task automatic check_low_addr(input string name, input t_low_addr exp,
                                  input t_low_addr act);
        if (act !== exp)
            stop_on_error($sformatf("FAILED %s: expected 0x%h, got 0x%h", name, exp, act));
    endtask

    task automatic check_keep(input string name, input t_data_keep exp, input t_data_keep act);
        if (act !== exp)
            stop_on_error($sformatf("FAILED %s: expected 0x%h, got 0x%h", name, exp, act));
    endtask

    // Present one beat and hold it until rx_ready is seen at an edge
    task automatic send_beat(input logic sop, input t_fmt_type fmt, input t_length len,
                             input t_req_id req_id, input t_tag tag, input t_addr addr);
        int waited;
        @(negedge csr_clk);
        rx_valid = 1'b1;
        rx_sop = sop;
        rx_fmt_type = fmt;
        rx_length = len;
        rx_req_id = req_id;
        rx_tag = tag;
        rx_addr = addr;
        waited = 0;
        @(posedge csr_clk);
        while (!rx_ready)
        begin
            if (waited >= WAIT_LIMIT)
                stop_on_error("RX beat was never accepted");
            @(posedge csr_clk);
            waited++;
        end
    endtask

    // MRd with its completion queued as owed
    task automatic send_read(input t_fmt_type fmt, input t_addr addr, input t_length len,
                             input t_tag tag);
        t_req_id rid;
        rid = {6'h28, tag};
        exp_q.push_back(model_cpl(fmt, addr, len, rid, tag));
        send_beat(1'b1, fmt, len, rid, tag, addr);
    endtask

    task automatic rx_idle();
        @(negedge csr_clk);
        rx_valid = 1'b0;
        rx_sop = 1'b0;
    endtask

    // Edges until a TX transfer, counted from the last edge
    task automatic wait_tx(output int cycles);
        cycles = 1;
        @(posedge csr_clk);
        while (!(tx_valid && tx_ready))
        begin
            if (cycles >= WAIT_LIMIT)
                stop_on_error("no completion appeared on the TX stream");
            @(posedge csr_clk);
            cycles++;
        end
    endtask

    task automatic check_cpl(input cpl_t exp);
        check_fmt("tx_fmt_type", FMT_CPLD, tx_fmt_type);
        check_length("tx_length", exp.length, tx_length);
        check_id("tx_req_id", exp.req_id, tx_req_id);
        check_id("tx_comp_id", exp.comp_id, tx_comp_id);
        check_tag("tx_tag", exp.tag, tx_tag);
        check_count("tx_byte_count", exp.byte_count, tx_byte_count);
        check_low_addr("tx_low_addr", exp.low_addr, tx_low_addr);
        check_data("tx_data", exp.data, tx_data);
        check_keep("tx_keep", exp.keep, tx_keep);
    endtask

    task automatic collect(input int n);
        int cycles;
        for (int i = 0; i < n; i++)
        begin
            wait_tx(cycles);
            if (exp_q.size() == 0)
                stop_on_error("completion arrived with no read outstanding");
            check_cpl(exp_q.pop_front());
        end
    endtask

    // Nothing more may come out once every read is answered
    task automatic check_quiet();
        repeat (10)
        begin
            @(posedge csr_clk);
            if (tx_valid)
                stop_on_error("extra completion without a matching read");
        end
    endtask

    // Single read whose completion transfers on the third edge after acceptance
    task automatic timed_read(input t_fmt_type fmt, input t_addr addr, input t_length len,
                              input t_tag tag);
        int cycles;
        send_read(fmt, addr, len, tag);
        rx_idle();
        wait_tx(cycles);
        if (cycles != 3)
            stop_on_error($sformatf("completion took %0d cycles instead of 3", cycles));
        check_cpl(exp_q.pop_front());
    endtask

    task automatic test_reset();
        @(posedge csr_clk);
        check_flag("tx_valid", 1'b0, tx_valid);
        check_flag("rx_ready", 1'b1, rx_ready);
    endtask

    task automatic test_reg_map();
        t_low_addr off;
        for (int i = 0; i < 3; i++)
        begin
            off = t_low_addr'(i * 8);
            timed_read(FMT_MRD32, {32'hfee0_0000 | 32'(off), 32'h0}, 10'd2, t_tag'(i));
            timed_read(FMT_MRD64, 64'h0000_0001_8000_0000 | 64'(off), 10'd2, t_tag'(i + 8));
        end
    endtask

    task automatic test_short_reads();
        t_low_addr offs[4];
        offs = '{7'h04, 7'h0c, 7'h14, 7'h3c};
        for (int i = 0; i < 4; i++)
        begin
            timed_read(FMT_MRD32, {32'hfee0_0000 | 32'(offs[i]), 32'h0}, 10'd1,
                       t_tag'(i + 16));
            timed_read(FMT_MRD64, 64'h0000_0002_0000_0000 | 64'(offs[i]), 10'd1,
                       t_tag'(i + 24));
        end
    endtask

    // Writes and continuation beats mixed in with reads
    task automatic test_dropped();
        fork
            begin
                send_read(FMT_MRD32, {32'h0000_1008, 32'h0}, 10'd2, 10'h031);
                send_beat(1'b1, 8'h40, 10'd1, 16'h0101, 10'h3e0, {32'h0000_1000, 32'h0});
                send_beat(1'b0, FMT_MRD64, 10'd2, 16'h0102, 10'h3e1, 64'h10);
                send_read(FMT_MRD64, 64'h0000_0003_0000_0014, 10'd1, 10'h032);
                send_beat(1'b1, 8'h60, 10'd2, 16'h0103, 10'h3e2, 64'h0);
                send_beat(1'b0, 8'h00, 10'd1, 16'h0104, 10'h3e3, 64'h0);
                send_read(FMT_MRD32, {32'h0000_1010, 32'h0}, 10'd2, 10'h033);
                rx_idle();
            end
            collect(3);
        join
        check_quiet();
    endtask

    // Random reads against random TX back-pressure
    task automatic test_backpressure();
        t_fmt_type s_fmt[STREAM_LEN];
        t_addr s_addr[STREAM_LEN];
        t_length s_len[STREAM_LEN];
        logic [31:0] r;
        logic [31:0] hi;
        for (int i = 0; i < STREAM_LEN; i++)
        begin
            r = lcg_next();
            hi = lcg_next();
            s_len[i] = r[30] ? 10'd2 : 10'd1;
            if (r[31])
            begin
                s_fmt[i] = FMT_MRD64;
                s_addr[i] = {hi, r[31:7], r[22:16]};
            end
            else
            begin
                s_fmt[i] = FMT_MRD32;
                s_addr[i] = {hi[31:7], r[22:16], 32'h0};
            end
        end
        stream_done = 1'b0;
        fork
            begin
                for (int i = 0; i < STREAM_LEN; i++)
                    send_read(s_fmt[i], s_addr[i], s_len[i], t_tag'(i + 256));
                rx_idle();
            end
            begin
                collect(STREAM_LEN);
                stream_done = 1'b1;
            end
            begin
                // About one cycle in four lets a completion out
                for (int n = 0; n < STREAM_LEN * WAIT_LIMIT && !stream_done; n++)
                begin
                    @(negedge csr_clk);
                    r = lcg_next();
                    tx_ready = r[31] & r[28];
                end
            end
        join
        @(negedge csr_clk);
        tx_ready = 1'b1;
        check_quiet();
    endtask

    initial
    begin
        csr_clk = 1'b0;
        csr_reset_n = 1'b0;
        rx_valid = 1'b0;
        rx_sop = 1'b0;
        rx_fmt_type = '0;
        rx_length = '0;
        rx_req_id = '0;
        rx_tag = '0;
        rx_addr = '0;
        tx_ready = 1'b1;
        // Non-zero slot identity so ID_L and comp_id are visible
        pf_num = 3'h5;
        vf_num = 11'h2a7;
        vf_active = 1'b1;
        lcg_state = 32'hff19;
        stream_done = 1'b0;
        repeat (2) @(posedge csr_clk);
        @(negedge csr_clk);
        csr_reset_n = 1'b1;
        test_reset();
        test_reg_map();
        test_short_reads();
        test_dropped();
        test_backpressure();
        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule

// File: mmio_tie_off_top.f
mmio_tie_off_pkg.sv
mmio_stage_if.sv
mmio_req_decode.sv
mmio_reg_lookup.sv
mmio_cpl_encode.sv
mmio_tie_off_top.sv
tb_mmio_tie_off.sv

// File: Makefile
# Verilator build and run of the MMIO tie-off testbench

VERILATOR ?= verilator
TOP ?= tb_mmio_tie_off
FILELIST ?= mmio_tie_off_top.f
BUILD_DIR ?= obj_dir
VFLAGS ?= --binary --timing

.PHONY: sim clean

# A $fatal in the testbench gives a non-zero exit status
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)
